/* include/idiv_defines.svh */
`ifndef IDIV_DEFINES_SVH
`define IDIV_DEFINES_SVH

// operand width of the divider
`define IDIV_WIDTH    32

// width of an alignment shift count
`define IDIV_SHIFT_W  $clog2(`IDIV_WIDTH)

// internal registers carry one extra sign bit
`define IDIV_EXT_W    (`IDIV_WIDTH + 1)

`endif

/* hdl/idiv_pkg.sv */
`include "idiv_defines.svh"

package idiv_pkg;

  typedef struct packed {
    logic [`IDIV_WIDTH-1:0] dividend;
    logic [`IDIV_WIDTH-1:0] divisor;
    logic                   is_signed;
  } idiv_req_t;

  typedef struct packed {
    logic [`IDIV_WIDTH-1:0] quotient;
    logic [`IDIV_WIDTH-1:0] remainder;
  } idiv_res_t;

  // per-cycle control word from the FSM to the datapath
  typedef struct packed {
    logic [1:0] opa_sel;
    logic       opa_ld;
    logic       opa_inv;
    logic       opa_clr;
    logic [3:0] opb_sel;
    logic       opb_ld;
    logic       opb_inv;
    logic       opb_clr;
    logic [3:0] opc_sel;
    logic       opc_ld;
    logic       latch_req;
    logic       adder_cin;
  } idiv_ctrl_t;

  typedef struct packed {
    logic zero_divisor;
    logic adder_neg;
    logic opa_neg;
    logic opc_neg;
  } idiv_stat_t;

  typedef enum logic [3:0] {
    IDLE,
    NEG_DIVISOR,
    NEG_DIVIDEND,
    ALIGN,
    ITERATE,
    REPAIR,
    NEG_REM,
    NEG_QUO,
    DONE
  } idiv_state_e;

  // one-hot mux selects, bit 3 down to bit 0
  localparam logic [1:0] OPA_SEL_REQ   = 2'b10;
  localparam logic [1:0] OPA_SEL_ADD   = 2'b01;
  localparam logic [3:0] OPB_SEL_ALIGN = 4'b1000;
  localparam logic [3:0] OPB_SEL_OPC   = 4'b0100;
  localparam logic [3:0] OPB_SEL_ADD   = 4'b0010;
  localparam logic [3:0] OPB_SEL_STEP  = 4'b0001;
  localparam logic [3:0] OPC_SEL_ALIGN = 4'b1000;
  localparam logic [3:0] OPC_SEL_REQ   = 4'b0100;
  localparam logic [3:0] OPC_SEL_ADD   = 4'b0010;
  localparam logic [3:0] OPC_SEL_STEP  = 4'b0001;

endpackage

/* hdl/idiv_leading_zeros.sv */
`timescale 1ns/100ps
`include "idiv_defines.svh"

module idiv_leading_zeros (
  input  logic [`IDIV_WIDTH-1:0]   word_i,
  output logic [`IDIV_SHIFT_W-1:0] zeros_o
);

  // ---------------------------------------------------------------------------
  // priority scan from the msb
  // ---------------------------------------------------------------------------

  // an all-zero word falls through to WIDTH-1
  always_comb begin : scan
    logic found;
    found   = 1'b0;
    zeros_o = (`IDIV_SHIFT_W)'(`IDIV_WIDTH - 1);
    for (int i = `IDIV_WIDTH - 1; i >= 0; i--) begin
      if (!found && word_i[i]) begin
        found   = 1'b1;
        zeros_o = (`IDIV_SHIFT_W)'(`IDIV_WIDTH - 1 - i);
      end
    end
  end

endmodule

/* hdl/idiv_datapath.sv */
`timescale 1ns/100ps
`include "idiv_defines.svh"

module idiv_datapath import idiv_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  idiv_req_t                req_i,
  input  idiv_ctrl_t               ctrl_i,
  output idiv_stat_t               stat_o,
  output logic [`IDIV_SHIFT_W-1:0] shift_cnt_o,
  output idiv_res_t                res_o
);

  // opa holds the divisor, then the remainder
  logic [`IDIV_EXT_W-1:0]   opa_r;
  // opb holds the shifted partial remainder
  logic [`IDIV_EXT_W-1:0]   opb_r;
  // opc holds the dividend bits, quotient bits enter at the lsb
  logic [`IDIV_EXT_W-1:0]   opc_r;
  logic                     signed_r;

  logic [`IDIV_EXT_W-1:0]   divisor_ext;
  logic [`IDIV_EXT_W-1:0]   dividend_ext;
  logic [`IDIV_EXT_W-1:0]   add_in_a;
  logic [`IDIV_EXT_W-1:0]   add_in_b;
  logic [`IDIV_EXT_W-1:0]   add_out;
  logic [`IDIV_EXT_W-1:0]   opb_step;
  logic [`IDIV_EXT_W-1:0]   opc_step;
  logic [`IDIV_EXT_W-1:0]   opb_align;
  logic [`IDIV_EXT_W-1:0]   opc_align;
  logic [`IDIV_SHIFT_W:0]   align_left;
  logic [`IDIV_EXT_W-1:0]   opa_mux;
  logic [`IDIV_EXT_W-1:0]   opb_mux;
  logic [`IDIV_EXT_W-1:0]   opc_mux;
  logic [`IDIV_SHIFT_W-1:0] lz_dividend;
  logic [`IDIV_SHIFT_W-1:0] lz_divisor;

  // and-or mux, data order follows the select bit order
  function automatic logic [`IDIV_EXT_W-1:0] mux4_onehot(
    input logic [3:0]             sel,
    input logic [`IDIV_EXT_W-1:0] d3,
    input logic [`IDIV_EXT_W-1:0] d2,
    input logic [`IDIV_EXT_W-1:0] d1,
    input logic [`IDIV_EXT_W-1:0] d0
  );
    return ({`IDIV_EXT_W{sel[3]}} & d3)
         | ({`IDIV_EXT_W{sel[2]}} & d2)
         | ({`IDIV_EXT_W{sel[1]}} & d1)
         | ({`IDIV_EXT_W{sel[0]}} & d0);
  endfunction

  // sign bit only for signed requests
  assign divisor_ext  = {req_i.is_signed & req_i.divisor[`IDIV_WIDTH-1], req_i.divisor};
  assign dividend_ext = {req_i.is_signed & req_i.dividend[`IDIV_WIDTH-1], req_i.dividend};

  // ---------------------------------------------------------------------------
  // shared adder
  // ---------------------------------------------------------------------------

  // invert and clear give negate, subtract and add from one adder
  assign add_in_a = ctrl_i.opa_clr ? '0 : (opa_r ^ {`IDIV_EXT_W{ctrl_i.opa_inv}});
  assign add_in_b = ctrl_i.opb_clr ? '0 : (opb_r ^ {`IDIV_EXT_W{ctrl_i.opb_inv}});
  assign add_out  = add_in_a + add_in_b + (`IDIV_EXT_W)'(ctrl_i.adder_cin);

  // one non-restoring step
  // next dividend bit into the remainder, inverted sign into the quotient
  assign opb_step = {add_out[`IDIV_WIDTH-1:0], opc_r[`IDIV_WIDTH]};
  assign opc_step = {opc_r[`IDIV_WIDTH-1:0], ~add_out[`IDIV_WIDTH]};

  // ---------------------------------------------------------------------------
  // alignment
  // ---------------------------------------------------------------------------

  idiv_leading_zeros lzc_dividend (
    .word_i  (opc_r[`IDIV_WIDTH-1:0]),
    .zeros_o (lz_dividend)
  );

  idiv_leading_zeros lzc_divisor (
    .word_i  (opa_r[`IDIV_WIDTH-1:0]),
    .zeros_o (lz_divisor)
  );

  // a divisor wider than the dividend needs a single step
  always_comb begin
    if (stat_o.zero_divisor) begin
      shift_cnt_o = (`IDIV_SHIFT_W)'(`IDIV_WIDTH - 1);
    end else if (lz_divisor < lz_dividend) begin
      shift_cnt_o = '0;
    end else begin
      shift_cnt_o = lz_divisor - lz_dividend;
    end
  end

  // known-zero quotient bits are skipped
  // opb gets the first shifted remainder, opc the rest left-aligned
  assign align_left = (`IDIV_SHIFT_W+1)'(`IDIV_EXT_W) - {1'b0, shift_cnt_o};
  assign opb_align  = opc_r >> shift_cnt_o;
  assign opc_align  = opc_r << align_left;

  // ---------------------------------------------------------------------------
  // operand registers
  // ---------------------------------------------------------------------------

  assign opa_mux = ({`IDIV_EXT_W{ctrl_i.opa_sel[1]}} & divisor_ext)
                 | ({`IDIV_EXT_W{ctrl_i.opa_sel[0]}} & add_out);
  assign opb_mux = mux4_onehot(ctrl_i.opb_sel, opb_align, opc_r, add_out, opb_step);
  assign opc_mux = mux4_onehot(ctrl_i.opc_sel, opc_align, dividend_ext, add_out, opc_step);

  always_ff @(posedge clk_i) begin
    if (ctrl_i.opa_ld) begin
      opa_r <= opa_mux;
    end
    if (ctrl_i.opb_ld) begin
      opb_r <= opb_mux;
    end
    if (ctrl_i.opc_ld) begin
      opc_r <= opc_mux;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      signed_r <= 1'b0;
    end else if (ctrl_i.latch_req) begin
      signed_r <= req_i.is_signed;
    end
  end

  assign stat_o.zero_divisor = ~(|opa_r);
  assign stat_o.adder_neg    = add_out[`IDIV_WIDTH];
  assign stat_o.opa_neg      = signed_r & opa_r[`IDIV_WIDTH];
  assign stat_o.opc_neg      = signed_r & opc_r[`IDIV_WIDTH];

  assign res_o.quotient  = opc_r[`IDIV_WIDTH-1:0];
  assign res_o.remainder = opa_r[`IDIV_WIDTH-1:0];

  // FSM select encodings must match the mux order here
  a_opb_sel_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ctrl_i.opb_ld |-> $onehot(ctrl_i.opb_sel)
  );

  a_opc_sel_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    ctrl_i.opc_ld |-> $onehot(ctrl_i.opc_sel)
  );

endmodule

/* hdl/idiv_controller.sv */
`timescale 1ns/100ps
`include "idiv_defines.svh"

module idiv_controller import idiv_pkg::*; (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     v_i,
  output logic                     ready_o,
  output logic                     v_o,
  input  logic                     yumi_i,
  input  idiv_stat_t               stat_i,
  input  logic [`IDIV_SHIFT_W-1:0] shift_cnt_i,
  output idiv_ctrl_t               ctrl_o
);

  idiv_state_e              state_r;
  idiv_state_e              state_nxt;
  logic [`IDIV_SHIFT_W-1:0] iter_cnt_r;
  // sign of the last step result, picks add or subtract
  logic                     neg_last_r;
  logic                     quo_neg_r;
  logic                     rem_neg_r;
  logic                     zero_div_r;

  // ---------------------------------------------------------------------------
  // state and step bookkeeping
  // ---------------------------------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_r    <= IDLE;
      iter_cnt_r <= '0;
      neg_last_r <= 1'b0;
      quo_neg_r  <= 1'b0;
      rem_neg_r  <= 1'b0;
      zero_div_r <= 1'b0;
    end else begin
      state_r <= state_nxt;
      case (state_r)
        NEG_DIVISOR: begin
          quo_neg_r <= stat_i.opa_neg;
        end
        NEG_DIVIDEND: begin
          // quotient is negative when exactly one operand is
          quo_neg_r <= quo_neg_r ^ stat_i.opc_neg;
          rem_neg_r <= stat_i.opc_neg;
        end
        ALIGN: begin
          iter_cnt_r <= shift_cnt_i;
          neg_last_r <= 1'b0;
          zero_div_r <= stat_i.zero_divisor;
        end
        ITERATE: begin
          iter_cnt_r <= iter_cnt_r - 1'b1;
          neg_last_r <= stat_i.adder_neg;
        end
        default: begin
        end
      endcase
    end
  end

  // ---------------------------------------------------------------------------
  // next state and control word
  // ---------------------------------------------------------------------------

  always_comb begin
    state_nxt = state_r;
    ctrl_o    = '0;
    ready_o   = 1'b0;
    v_o       = 1'b0;

    case (state_r)
      IDLE: begin
        ready_o = 1'b1;
        if (v_i) begin
          ctrl_o.latch_req = 1'b1;
          ctrl_o.opa_sel   = OPA_SEL_REQ;
          ctrl_o.opa_ld    = 1'b1;
          ctrl_o.opc_sel   = OPC_SEL_REQ;
          ctrl_o.opc_ld    = 1'b1;
          state_nxt        = NEG_DIVISOR;
        end
      end

      // opa = -opa when negative, dividend copied into opb
      NEG_DIVISOR: begin
        ctrl_o.opa_inv   = 1'b1;
        ctrl_o.opb_clr   = 1'b1;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opa_sel   = OPA_SEL_ADD;
        ctrl_o.opa_ld    = stat_i.opa_neg;
        ctrl_o.opb_sel   = OPB_SEL_OPC;
        ctrl_o.opb_ld    = 1'b1;
        state_nxt        = NEG_DIVIDEND;
      end

      NEG_DIVIDEND: begin
        ctrl_o.opa_clr   = 1'b1;
        ctrl_o.opb_inv   = 1'b1;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opc_sel   = OPC_SEL_ADD;
        ctrl_o.opc_ld    = stat_i.opc_neg;
        state_nxt        = ALIGN;
      end

      ALIGN: begin
        ctrl_o.opb_sel = OPB_SEL_ALIGN;
        ctrl_o.opb_ld  = 1'b1;
        ctrl_o.opc_sel = OPC_SEL_ALIGN;
        ctrl_o.opc_ld  = 1'b1;
        state_nxt      = ITERATE;
      end

      // subtract after a positive result, add after a negative one
      ITERATE: begin
        ctrl_o.opa_inv   = ~neg_last_r;
        ctrl_o.adder_cin = ~neg_last_r;
        ctrl_o.opb_ld    = 1'b1;
        ctrl_o.opc_sel   = OPC_SEL_STEP;
        ctrl_o.opc_ld    = 1'b1;
        if (iter_cnt_r == '0) begin
          // keep the final remainder unshifted
          ctrl_o.opb_sel = OPB_SEL_ADD;
          state_nxt      = REPAIR;
        end else begin
          ctrl_o.opb_sel = OPB_SEL_STEP;
        end
      end

      // remainder moves to opa, plus the divisor if it went negative
      REPAIR: begin
        ctrl_o.opa_clr = ~neg_last_r;
        ctrl_o.opa_sel = OPA_SEL_ADD;
        ctrl_o.opa_ld  = 1'b1;
        ctrl_o.opb_sel = OPB_SEL_OPC;
        ctrl_o.opb_ld  = 1'b1;
        state_nxt      = NEG_REM;
      end

      NEG_REM: begin
        ctrl_o.opa_inv   = 1'b1;
        ctrl_o.opb_clr   = 1'b1;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opa_sel   = OPA_SEL_ADD;
        ctrl_o.opa_ld    = rem_neg_r;
        state_nxt        = NEG_QUO;
      end

      // divide by zero keeps the all-ones quotient
      NEG_QUO: begin
        ctrl_o.opa_clr   = 1'b1;
        ctrl_o.opb_inv   = 1'b1;
        ctrl_o.adder_cin = 1'b1;
        ctrl_o.opc_sel   = OPC_SEL_ADD;
        ctrl_o.opc_ld    = quo_neg_r & ~zero_div_r;
        state_nxt        = DONE;
      end

      DONE: begin
        v_o = 1'b1;
        if (yumi_i) begin
          state_nxt = IDLE;
        end
      end

      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  a_ready_valid_excl : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    !(v_o && ready_o)
  );

  // the last step leaves ITERATE before the counter wraps
  a_iter_no_wrap : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (state_r == ITERATE) |=> (state_r != ITERATE) || (iter_cnt_r < $past(iter_cnt_r))
  );

endmodule

/* hdl/idiv_iterative.sv */
`timescale 1ns/100ps
`include "idiv_defines.svh"

module idiv_iterative import idiv_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  logic      v_i,
  input  idiv_req_t req_i,
  output logic      ready_o,
  output logic      v_o,
  output idiv_res_t res_o,
  input  logic      yumi_i
);

  idiv_ctrl_t               ctrl;
  idiv_stat_t               stat;
  logic [`IDIV_SHIFT_W-1:0] shift_cnt;

  idiv_controller ctrl0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .v_i         (v_i),
    .ready_o     (ready_o),
    .v_o         (v_o),
    .yumi_i      (yumi_i),
    .stat_i      (stat),
    .shift_cnt_i (shift_cnt),
    .ctrl_o      (ctrl)
  );

  idiv_datapath dp0 (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (req_i),
    .ctrl_i      (ctrl),
    .stat_o      (stat),
    .shift_cnt_o (shift_cnt),
    .res_o       (res_o)
  );

  // the consumer may only take a result that is offered
  a_yumi_needs_valid : assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    yumi_i |-> v_o
  );

endmodule

/* testbench/idiv_tb.sv */
`timescale 1ns/100ps
`include "idiv_defines.svh"

module idiv_tb import idiv_pkg::*;;

  localparam int NUM_DIRECTED = 19;
  localparam int NUM_RANDOM   = 16;
  localparam int NUM_BP       = 6;
  localparam int NUM_OPS      = NUM_DIRECTED + 2 * NUM_RANDOM + NUM_BP;
  localparam int TIMEOUT_CYC  = NUM_OPS * (`IDIV_WIDTH + 16) + 100;
  localparam logic [`IDIV_WIDTH-1:0] MOST_NEG = {1'b1, {(`IDIV_WIDTH-1){1'b0}}};

  logic      clk;
  logic      rst_n;
  logic      v_in;
  idiv_req_t req;
  logic      ready;
  logic      v_out;
  idiv_res_t res;
  logic      yumi;

  logic [30:0] lfsr_q;
  int          error_count;
  int          check_count;
  int          cycle_cnt;

  idiv_iterative dut0 (
    .clk_i   (clk),
    .rst_n_i (rst_n),
    .v_i     (v_in),
    .req_i   (req),
    .ready_o (ready),
    .v_o     (v_out),
    .res_o   (res),
    .yumi_i  (yumi)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Verification failed");
      $finish;
    end
  end

  // ------------------------------------------------------------------------
  // stimulus helpers
  // ------------------------------------------------------------------------

  // taps x^31 + x^28 + 1
  function automatic logic next_lfsr_bit();
    logic fb;
    fb     = lfsr_q[30] ^ lfsr_q[27];
    lfsr_q = {lfsr_q[29:0], fb};
    return fb;
  endfunction

  function automatic logic [`IDIV_WIDTH-1:0] random_bits(input int n);
    logic [`IDIV_WIDTH-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[`IDIV_WIDTH-2:0], next_lfsr_bit()};
    end
    return v;
  endfunction

  function automatic idiv_req_t make_req(input logic [`IDIV_WIDTH-1:0] dvd,
                                         input logic [`IDIV_WIDTH-1:0] dvs,
                                         input logic sgn);
    idiv_req_t r;
    r.dividend  = dvd;
    r.divisor   = dvs;
    r.is_signed = sgn;
    return r;
  endfunction

  // truncating division, remainder follows the dividend sign
  function automatic idiv_res_t expected_result(input idiv_req_t r);
    idiv_res_t                     e;
    logic signed [`IDIV_WIDTH-1:0] sa;
    logic signed [`IDIV_WIDTH-1:0] sb;
    sa = r.dividend;
    sb = r.divisor;
    if (r.divisor == '0) begin
      e.quotient  = '1;
      e.remainder = r.dividend;
    end else if (!r.is_signed) begin
      e.quotient  = r.dividend / r.divisor;
      e.remainder = r.dividend % r.divisor;
    end else if (r.dividend == MOST_NEG && r.divisor == '1) begin
      // overflow case wraps back to the most negative number
      e.quotient  = MOST_NEG;
      e.remainder = '0;
    end else begin
      e.quotient  = sa / sb;
      e.remainder = sa % sb;
    end
    return e;
  endfunction

  // one request, hold the result for hold cycles, then yumi
  task automatic divide_once(input idiv_req_t r, input int hold);
    idiv_res_t exp_res;
    idiv_res_t got;
    logic      accepted;
    exp_res  = expected_result(r);
    accepted = 1'b0;
    v_in     = 1'b1;
    req      = r;
    while (!accepted) begin
      @(negedge clk);
      accepted = ready;
      @(posedge clk);
      #2;
    end
    v_in = 1'b0;
    check_count++;
    assert (!ready) else begin
      error_count++;
      $display("ERROR at %0t: ready_o still high after the request", $time);
    end
    @(negedge clk);
    while (!v_out) begin
      check_count++;
      assert (!ready) else begin
        error_count++;
        $display("ERROR at %0t: ready_o high while busy", $time);
      end
      @(negedge clk);
    end
    got = res;
    check_count++;
    assert (got == exp_res) else begin
      error_count++;
      $display("ERROR at %0t: %h / %h signed=%0b gave q=%h r=%h, expected q=%h r=%h",
               $time, r.dividend, r.divisor, r.is_signed, got.quotient, got.remainder,
               exp_res.quotient, exp_res.remainder);
    end
    repeat (hold) begin
      @(negedge clk);
      check_count++;
      assert (v_out && !ready && res == got) else begin
        error_count++;
        $display("ERROR at %0t: result not held under back-pressure", $time);
      end
    end
    @(posedge clk);
    #2;
    yumi = 1'b1;
    @(posedge clk);
    #2;
    yumi = 1'b0;
    check_count++;
    assert (ready && !v_out) else begin
      error_count++;
      $display("ERROR at %0t: ready_o=%0b v_o=%0b after yumi", $time, ready, v_out);
    end
  endtask

  // ------------------------------------------------------------------------
  // directed tests
  // ------------------------------------------------------------------------

  task automatic after_reset_handshake();
    @(negedge clk);
    check_count++;
    assert (ready && !v_out) else begin
      error_count++;
      $display("ERROR at %0t: ready_o=%0b v_o=%0b after reset", $time, ready, v_out);
    end
    @(posedge clk);
    #2;
    divide_once(make_req(32'd1000, 32'd10, 1'b0), 0);
  endtask

  task automatic unsigned_division();
    divide_once(make_req(32'd100, 32'd7, 1'b0), 0);
    divide_once(make_req(32'd7, 32'd100, 1'b0), 0);
    divide_once(make_req(32'hffff_ffff, 32'd1, 1'b0), 0);
    divide_once(make_req(32'd12345, 32'd1, 1'b0), 0);
    divide_once(make_req(32'hffff_ffff, 32'hffff_ffff, 1'b0), 0);
    divide_once(make_req(32'd0, 32'd5, 1'b0), 0);
    divide_once(make_req(32'h8000_0000, 32'd3, 1'b0), 0);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      divide_once(make_req(random_bits(32), random_bits(32) >> random_bits(5), 1'b0), 0);
    end
  endtask

  task automatic signed_division();
    divide_once(make_req(-32'sd7, 32'sd2, 1'b1), 0);
    divide_once(make_req(32'sd7, -32'sd2, 1'b1), 0);
    divide_once(make_req(-32'sd7, -32'sd2, 1'b1), 0);
    divide_once(make_req(32'sd7, 32'sd2, 1'b1), 0);
    divide_once(make_req(MOST_NEG, '1, 1'b1), 0);
    divide_once(make_req(MOST_NEG, 32'sd1, 1'b1), 0);
    divide_once(make_req(-32'sd1, MOST_NEG, 1'b1), 0);
    for (int i = 0; i < NUM_RANDOM; i++) begin
      divide_once(make_req(random_bits(32), random_bits(32) >> random_bits(5), 1'b1), 0);
    end
  endtask

  task automatic zero_divisor();
    divide_once(make_req(32'd123, 32'd0, 1'b0), 0);
    divide_once(make_req(32'hffff_ffff, 32'd0, 1'b0), 0);
    divide_once(make_req(-32'sd5, 32'd0, 1'b1), 0);
    divide_once(make_req(MOST_NEG, 32'd0, 1'b1), 0);
  endtask

  task automatic back_pressure();
    int hold;
    for (int i = 0; i < NUM_BP; i++) begin
      hold = int'(random_bits(3)) + 1;
      divide_once(make_req(random_bits(32), random_bits(16), next_lfsr_bit()), hold);
    end
  endtask

  initial begin
    clk         = 1'b0;
    rst_n       = 1'b0;
    v_in        = 1'b0;
    req         = '0;
    yumi        = 1'b0;
    lfsr_q      = 31'd99;
    error_count = 0;
    check_count = 0;
    cycle_cnt   = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    after_reset_handshake();
    unsigned_division();
    signed_division();
    zero_divisor();
    back_pressure();

    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+include
hdl/idiv_pkg.sv
hdl/idiv_leading_zeros.sv
hdl/idiv_datapath.sv
hdl/idiv_controller.sv
hdl/idiv_iterative.sv
testbench/idiv_tb.sv
